//--- Makefile
VERILATOR ?= verilator
TOP ?= aesTb
RTL_TOP ?= aesTop
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
EXTRA_FLAGS ?=

PASS_MSG := All checks passed
SIM_FLAGS := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) $(EXTRA_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall --timing --timescale 1ns/1ps --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- flist.f
rtl/aesPkg.sv
rtl/aesSbox.sv
rtl/aesRoundLogic.sv
rtl/aesKeyExpand.sv
rtl/aesCore.sv
rtl/aesRegs.sv
rtl/aesTop.sv
sim/aesClkGen.sv
sim/aesCore_assert.sv
sim/aesTb.sv

//--- rtl/aesCore.sv
`timescale 1ns/1ps
`default_nettype none

module aesCore (
	input logic clk,
	input logic rstN,
	input logic start,
	input logic decrypt,
	input aesPkg::block_t dataIn,
	input logic keyReady,
	input aesPkg::block_t roundKey,
	output aesPkg::roundIdx_t roundSel,
	output logic busy,
	output logic done,
	output aesPkg::block_t dataOut
);
	import aesPkg::*;

	block_t state;
	block_t roundOut;
	roundIdx_t roundCnt;
	logic dirReg;
	logic loading;
	logic lastRound;

	// first busy cycle only whitens the input block
	assign loading = busy && (roundCnt == '0);
	assign lastRound = (roundCnt == roundIdx_t'(numRounds));

	always_comb
	begin
		if (loading || !busy)
			roundSel = decrypt ? roundIdx_t'(numRounds) : '0;
		else
			roundSel = dirReg ? roundIdx_t'(numRounds) - roundCnt : roundCnt;
	end

	aesRoundLogic i_roundLogic (
		.stateIn(state),
		.roundKey(roundKey),
		.decrypt(dirReg),
		.finalRound(lastRound),
		.stateOut(roundOut)
	);

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			busy <= 1'b0;
			done <= 1'b0;
			roundCnt <= '0;
			dirReg <= 1'b0;
			state <= '0;
		end
		else if (!busy)
		begin
			if (start && keyReady)
			begin
				busy <= 1'b1;
				done <= 1'b0;
				roundCnt <= '0;
			end
		end
		else if (loading)
		begin
			state <= dataIn ^ roundKey;
			dirReg <= decrypt;
			roundCnt <= roundIdx_t'(1);
		end
		else
		begin
			state <= roundOut;
			roundCnt <= roundCnt + 1'b1;
			if (lastRound)
			begin
				busy <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	assign dataOut = state;

endmodule

`default_nettype wire

//--- rtl/aesKeyExpand.sv
`timescale 1ns/1ps
`default_nettype none

module aesKeyExpand (
	input logic clk,
	input logic rstN,
	input logic keyLoad,
	input aesPkg::block_t cipherKey,
	input logic busy,
	input aesPkg::roundIdx_t roundSel,
	output aesPkg::block_t roundKey,
	output logic keyReady
);
	import aesPkg::*;

	block_t keyStore [numRounds + 1];
	block_t lastKey;
	block_t nextKey;
	roundIdx_t stepCnt;
	logic running;
	logic loadOk;
	logic [7:0] rcon;
	logic [31:0] rotWord;
	logic [31:0] subWord;
	logic [31:0] temp;

	// the core reads keys while busy, so a reload waits
	assign loadOk = keyLoad && !busy;

	// last word of the previous key, rotated by one byte
	assign rotWord = {lastKey[23:0], lastKey[31:24]};

	for (genvar i = 0; i < 4; i++)
	begin : gSubWord
		aesSbox i_sbox (
			.inByte(rotWord[8 * i +: 8]),
			.inverse(1'b0),
			.outByte(subWord[8 * i +: 8])
		);
	end

	assign temp = subWord ^ {rcon, 24'h000000};
	assign nextKey[127:96] = lastKey[127:96] ^ temp;
	assign nextKey[95:64] = lastKey[95:64] ^ nextKey[127:96];
	assign nextKey[63:32] = lastKey[63:32] ^ nextKey[95:64];
	assign nextKey[31:0] = lastKey[31:0] ^ nextKey[63:32];

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			stepCnt <= '0;
			running <= 1'b0;
			keyReady <= 1'b0;
			rcon <= '0;
		end
		else if (loadOk)
		begin
			stepCnt <= roundIdx_t'(1);
			running <= 1'b1;
			keyReady <= 1'b0;
			rcon <= 8'h01;
		end
		else if (running)
		begin
			stepCnt <= stepCnt + 1'b1;
			rcon <= gfTimes2(rcon);
			if (stepCnt == roundIdx_t'(numRounds))
			begin
				running <= 1'b0;
				keyReady <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (loadOk)
		begin
			keyStore[0] <= cipherKey;
			lastKey <= cipherKey;
		end
		else if (running)
		begin
			keyStore[stepCnt] <= nextKey;
			lastKey <= nextKey;
		end
	end

	assign roundKey = keyStore[roundSel];

endmodule

`default_nettype wire

//--- rtl/aesPkg.sv
`default_nettype none

package aesPkg;

	localparam int blockWidth = 128;
	localparam int wordWidth = 32;
	localparam int numRounds = 10;

	typedef logic [3:0] roundIdx_t;
	// byte 0 sits in the top eight bits, columns of four bytes
	typedef logic [blockWidth-1:0] block_t;

	localparam logic [7:0] regCtrl = 8'h00;
	localparam logic [7:0] regStatus = 8'h04;
	localparam logic [7:0] regKeyBase = 8'h10;
	localparam logic [7:0] regDataInBase = 8'h20;
	localparam logic [7:0] regDataOutBase = 8'h30;

	function automatic logic [7:0] gfTimes2(input logic [7:0] b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

	// shift and add, reducing on every doubling
	function automatic logic [7:0] gfMul(input logic [7:0] a, input logic [7:0] b);
		logic [7:0] acc;
		logic [7:0] p;
		acc = '0;
		p = a;
		for (int i = 0; i < 8; i++)
		begin
			if (b[i])
				acc ^= p;
			p = gfTimes2(p);
		end
		return acc;
	endfunction

endpackage

`default_nettype wire

//--- rtl/aesRegs.sv
`timescale 1ns/1ps
`default_nettype none

module aesRegs (
	input logic clk,
	input logic rstN,
	input logic wbCyc,
	input logic wbStb,
	input logic wbWe,
	input logic [7:0] wbAdr,
	input logic [aesPkg::wordWidth-1:0] wbDatW,
	output logic [aesPkg::wordWidth-1:0] wbDatR,
	output logic wbAck,
	output logic start,
	output logic decrypt,
	output logic keyLoad,
	output aesPkg::block_t cipherKey,
	output aesPkg::block_t dataIn,
	input logic busy,
	input logic done,
	input logic keyReady,
	input aesPkg::block_t dataOut
);
	import aesPkg::*;

	logic access;
	logic wrEn;
	logic ctrlWr;
	logic keyHit;
	logic dataInHit;
	logic dataOutHit;
	logic [1:0] wordIdx;
	logic [wordWidth-1:0] rdData;

	// one wait cycle per access, ack never held for two
	assign access = wbCyc && wbStb && !wbAck;
	assign wrEn = access && wbWe;
	assign wordIdx = wbAdr[3:2];

	assign keyHit = (wbAdr[7:4] == regKeyBase[7:4]);
	assign dataInHit = (wbAdr[7:4] == regDataInBase[7:4]);
	assign dataOutHit = (wbAdr[7:4] == regDataOutBase[7:4]);
	assign ctrlWr = wrEn && (wbAdr[7:2] == regCtrl[7:2]);

	// pulses line up with the acknowledging edge
	assign start = ctrlWr && wbDatW[0];
	assign keyLoad = ctrlWr && wbDatW[2];

	always_comb
	begin
		rdData = '0;
		if (wbAdr[7:2] == regStatus[7:2])
			rdData[2:0] = {keyReady, done, busy};
		else if (keyHit)
			rdData = cipherKey[blockWidth - 1 - wordWidth * wordIdx -: wordWidth];
		else if (dataInHit)
			rdData = dataIn[blockWidth - 1 - wordWidth * wordIdx -: wordWidth];
		else if (dataOutHit)
			rdData = dataOut[blockWidth - 1 - wordWidth * wordIdx -: wordWidth];
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			wbAck <= 1'b0;
			wbDatR <= '0;
			decrypt <= 1'b0;
			cipherKey <= '0;
			dataIn <= '0;
		end
		else
		begin
			wbAck <= access;
			if (access)
				wbDatR <= rdData;
			if (ctrlWr)
				decrypt <= wbDatW[1];
			if (wrEn && keyHit)
				cipherKey[blockWidth - 1 - wordWidth * wordIdx -: wordWidth] <= wbDatW;
			if (wrEn && dataInHit)
				dataIn[blockWidth - 1 - wordWidth * wordIdx -: wordWidth] <= wbDatW;
		end
	end

endmodule

`default_nettype wire

//--- rtl/aesRoundLogic.sv
`timescale 1ns/1ps
`default_nettype none

module aesRoundLogic (
	input aesPkg::block_t stateIn,
	input aesPkg::block_t roundKey,
	input logic decrypt,
	input logic finalRound,
	output aesPkg::block_t stateOut
);
	import aesPkg::*;

	block_t shifted;
	block_t subbed;
	block_t mixIn;
	block_t mixed;
	block_t mixOut;

	// row r of output takes coefficient (j - r) mod 4 for input byte j
	function automatic logic [31:0] mixColumn(input logic [31:0] col, input logic inv);
		logic [31:0] coef;
		logic [31:0] res;
		coef = inv ? 32'h0e0b0d09 : 32'h02030101;
		res = '0;
		for (int r = 0; r < 4; r++)
		begin
			for (int j = 0; j < 4; j++)
			begin
				res[31 - 8 * r -: 8] ^= gfMul(coef[31 - 8 * ((j - r + 4) % 4) -: 8],
					col[31 - 8 * j -: 8]);
			end
		end
		return res;
	endfunction

	// row shift first, it commutes with the byte substitution
	for (genvar b = 0; b < 16; b++)
	begin : gByte
		localparam int row = b % 4;
		localparam int col = b / 4;
		localparam int fwdSrc = 4 * ((col + row) % 4) + row;
		localparam int invSrc = 4 * ((col + 4 - row) % 4) + row;

		assign shifted[blockWidth - 1 - 8 * b -: 8] = decrypt
			? stateIn[blockWidth - 1 - 8 * invSrc -: 8]
			: stateIn[blockWidth - 1 - 8 * fwdSrc -: 8];

		aesSbox i_sbox (
			.inByte(shifted[blockWidth - 1 - 8 * b -: 8]),
			.inverse(decrypt),
			.outByte(subbed[blockWidth - 1 - 8 * b -: 8])
		);
	end

	// inverse direction adds the key ahead of the column mix
	assign mixIn = decrypt ? (subbed ^ roundKey) : subbed;

	for (genvar c = 0; c < 4; c++)
	begin : gColumn
		assign mixed[blockWidth - 1 - 32 * c -: 32] =
			mixColumn(mixIn[blockWidth - 1 - 32 * c -: 32], decrypt);
	end

	assign mixOut = finalRound ? mixIn : mixed;
	assign stateOut = decrypt ? mixOut : (mixOut ^ roundKey);

endmodule

`default_nettype wire

//--- rtl/aesSbox.sv
`timescale 1ns/1ps
`default_nettype none

module aesSbox (
	input logic [7:0] inByte,
	input logic inverse,
	output logic [7:0] outByte
);
	import aesPkg::*;

	logic [7:0] invIn;
	logic [7:0] invOut;

	function automatic logic [7:0] rotl(input logic [7:0] b, input int n);
		return (b << n) | (b >> (8 - n));
	endfunction

	// b^254 equals the inverse, and zero maps to zero on its own
	function automatic logic [7:0] gfInverse(input logic [7:0] b);
		logic [7:0] sq;
		logic [7:0] acc;
		sq = b;
		acc = 8'h01;
		for (int i = 1; i < 8; i++)
		begin
			sq = gfMul(sq, sq);
			acc = gfMul(acc, sq);
		end
		return acc;
	endfunction

	always_comb
	begin
		// inverse affine map runs before the inversion
		invIn = inverse ? (rotl(inByte, 1) ^ rotl(inByte, 3) ^ rotl(inByte, 6) ^ 8'h05)
			: inByte;
		invOut = gfInverse(invIn);
		outByte = inverse ? invOut
			: (invOut ^ rotl(invOut, 1) ^ rotl(invOut, 2) ^ rotl(invOut, 3)
			^ rotl(invOut, 4) ^ 8'h63);
	end

endmodule

`default_nettype wire

//--- rtl/aesTop.sv
`timescale 1ns/1ps
`default_nettype none

module aesTop (
	input logic clk,
	input logic rstN,
	input logic wbCyc,
	input logic wbStb,
	input logic wbWe,
	input logic [7:0] wbAdr,
	input logic [aesPkg::wordWidth-1:0] wbDatW,
	output logic [aesPkg::wordWidth-1:0] wbDatR,
	output logic wbAck
);
	import aesPkg::*;

	logic start;
	logic decrypt;
	logic keyLoad;
	logic busy;
	logic done;
	logic keyReady;
	block_t cipherKey;
	block_t dataIn;
	block_t dataOut;
	block_t roundKey;
	roundIdx_t roundSel;

	aesRegs i_regs (
		.clk(clk),
		.rstN(rstN),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDatW(wbDatW),
		.wbDatR(wbDatR),
		.wbAck(wbAck),
		.start(start),
		.decrypt(decrypt),
		.keyLoad(keyLoad),
		.cipherKey(cipherKey),
		.dataIn(dataIn),
		.busy(busy),
		.done(done),
		.keyReady(keyReady),
		.dataOut(dataOut)
	);

	aesKeyExpand i_keyExpand (
		.clk(clk),
		.rstN(rstN),
		.keyLoad(keyLoad),
		.cipherKey(cipherKey),
		.busy(busy),
		.roundSel(roundSel),
		.roundKey(roundKey),
		.keyReady(keyReady)
	);

	aesCore i_core (
		.clk(clk),
		.rstN(rstN),
		.start(start),
		.decrypt(decrypt),
		.dataIn(dataIn),
		.keyReady(keyReady),
		.roundKey(roundKey),
		.roundSel(roundSel),
		.busy(busy),
		.done(done),
		.dataOut(dataOut)
	);

endmodule

`default_nettype wire

//--- sim/aesClkGen.sv
`timescale 1ns/1ps
`default_nettype none

module aesClkGen (
	output logic clk,
	output logic rstN
);
	localparam int resetCycles = 8;

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// release off the edge, like every other driven input
	initial
	begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		#0.5;
		rstN = 1'b1;
	end

endmodule

`default_nettype wire

//--- sim/aesCore_assert.sv
`timescale 1ns/1ps
`default_nettype none

module aesCoreAssert (
	input logic clk,
	input logic rstN,
	input logic start,
	input logic keyReady,
	input logic busy,
	input logic done
);
	logic accepted;

	assign accepted = start && keyReady && !busy;

	doneBusyExclusive: assert property (@(posedge clk) disable iff (!rstN)
		!(busy && done))
		else $error("busy and done are high together");

	// one whitening edge plus ten round edges
	busyLength: assert property (@(posedge clk) disable iff (!rstN)
		accepted |-> ##11 busy ##1 !busy)
		else $error("busy did not fall eleven cycles after start");

	doneHeld: assert property (@(posedge clk) disable iff (!rstN)
		done && !accepted |=> done)
		else $error("done dropped without a new start");

endmodule

bind aesCore aesCoreAssert i_coreAssert (
	.clk(clk),
	.rstN(rstN),
	.start(start),
	.keyReady(keyReady),
	.busy(busy),
	.done(done)
);

`default_nettype wire

//--- sim/aesTb.sv
`timescale 1ns/1ps
`default_nettype none

module aesTb;
	import aesPkg::*;

	localparam int numEntries = 3;
	localparam int numRandom = 16;
	localparam int resetCycles = 8;
	localparam int cyclesPerTest = 200;
	// one extra budget covers the reset and idle tests
	localparam int watchdogCycles = (numEntries + numRandom + 1) * cyclesPerTest + resetCycles;
	localparam int ackLimit = 8;
	localparam int pollLimit = 40;

	localparam logic [1:0] modeEncFirst = 2'd0;
	localparam logic [1:0] modeDecFirst = 2'd1;
	localparam logic [1:0] modeDoubleStart = 2'd2;

	logic clk;
	logic rstN;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	logic [7:0] wbAdr;
	logic [wordWidth-1:0] wbDatW;
	logic [wordWidth-1:0] wbDatR;
	logic wbAck;

	block_t tabKey [numEntries];
	block_t tabPlain [numEntries];
	block_t tabCipher [numEntries];
	logic [1:0] tabMode [numEntries];

	int errorCount;
	int testCount;
	int errorsAtStart;
	logic [31:0] rngState;

	aesClkGen i_clkGen (
		.clk(clk),
		.rstN(rstN)
	);

	aesTop i_dut (
		.clk(clk),
		.rstN(rstN),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDatW(wbDatW),
		.wbDatR(wbDatR),
		.wbAck(wbAck)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic block_t randomBlock();
		block_t r;
		r = '0;
		for (int i = 0; i < 4; i++)
		begin
			rngState = xorshift32(rngState);
			r = {r[95:0], rngState};
		end
		return r;
	endfunction

	task automatic checkValue(input string what, input logic [127:0] got,
		input logic [127:0] expected);
		assert (got === expected)
		else
		begin
			errorCount++;
			$display("error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
		end
	endtask

	// inputs change half a nanosecond after the edge, ack seen the same way
	task automatic writeWord(input logic [7:0] addr, input logic [31:0] data);
		int waitCnt;
		@(posedge clk);
		#0.5;
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbWe = 1'b1;
		wbAdr = addr;
		wbDatW = data;
		waitCnt = 0;
		do
		begin
			@(posedge clk);
			#0.5;
			waitCnt++;
		end
		while (!wbAck && waitCnt < ackLimit);
		assert (wbAck)
		else
		begin
			errorCount++;
			$display("bus write to address %h was never acknowledged", addr);
		end
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
	endtask

	task automatic readWord(input logic [7:0] addr, output logic [31:0] data);
		int waitCnt;
		@(posedge clk);
		#0.5;
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbWe = 1'b0;
		wbAdr = addr;
		waitCnt = 0;
		do
		begin
			@(posedge clk);
			#0.5;
			waitCnt++;
		end
		while (!wbAck && waitCnt < ackLimit);
		assert (wbAck)
		else
		begin
			errorCount++;
			$display("bus read from address %h was never acknowledged", addr);
		end
		data = wbDatR;
		wbCyc = 1'b0;
		wbStb = 1'b0;
	endtask

	// word 0 of each group carries the top 32 bits
	task automatic writeBlock(input logic [7:0] base, input block_t blk);
		for (int i = 0; i < 4; i++)
			writeWord(base + 8'(4 * i), blk[127 - 32 * i -: 32]);
	endtask

	task automatic readBlock(input logic [7:0] base, output block_t blk);
		logic [31:0] word;
		for (int i = 0; i < 4; i++)
		begin
			readWord(base + 8'(4 * i), word);
			blk[127 - 32 * i -: 32] = word;
		end
	endtask

	task automatic loadKey(input block_t key);
		logic [31:0] status;
		int polls;
		writeBlock(regKeyBase, key);
		writeWord(regCtrl, 32'h4);
		polls = 0;
		do
		begin
			readWord(regStatus, status);
			polls++;
		end
		while (!status[2] && polls < pollLimit);
		assert (status[2])
		else
		begin
			errorCount++;
			$display("key ready never came up after a key load");
		end
	endtask

	task automatic runBlock(input logic dec, input block_t blkIn, input logic doubleStart,
		output block_t blkOut);
		logic [31:0] status;
		int polls;
		writeBlock(regDataInBase, blkIn);
		writeWord(regCtrl, {30'b0, dec, 1'b1});
		// lands while busy so a restart would run the other way
		if (doubleStart)
			writeWord(regCtrl, {30'b0, !dec, 1'b1});
		polls = 0;
		do
		begin
			readWord(regStatus, status);
			polls++;
		end
		while (!status[1] && polls < pollLimit);
		assert (status[1])
		else
		begin
			errorCount++;
			$display("done never came up after a start");
		end
		readBlock(regDataOutBase, blkOut);
	endtask

	task automatic startTest();
		errorsAtStart = errorCount;
	endtask

	task automatic reportTest(input string name);
		testCount++;
		$display("test %0d %s: %s", testCount, name,
			(errorCount == errorsAtStart) ? "ok" : "FAILED");
	endtask

	initial
	begin
		repeat (watchdogCycles) @(posedge clk);
		$display("timeout: the run did not finish within %0d cycles", watchdogCycles);
		$display("Checks failed");
		$finish;
	end

	initial
	begin
		logic [31:0] word;
		block_t blk;
		block_t key;
		block_t plain;
		block_t cipher;

		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		wbAdr = '0;
		wbDatW = '0;
		errorCount = 0;
		testCount = 0;
		errorsAtStart = 0;
		rngState = 32'd47;

		// FIPS-197 appendix B, appendix C.1, all-zero key and block
		tabKey[0] = 128'h2b7e151628aed2a6abf7158809cf4f3c;
		tabPlain[0] = 128'h3243f6a8885a308d313198a2e0370734;
		tabCipher[0] = 128'h3925841d02dc09fbdc118597196a0b32;
		tabMode[0] = modeEncFirst;
		tabKey[1] = 128'h000102030405060708090a0b0c0d0e0f;
		tabPlain[1] = 128'h00112233445566778899aabbccddeeff;
		tabCipher[1] = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
		tabMode[1] = modeDecFirst;
		tabKey[2] = '0;
		tabPlain[2] = '0;
		tabCipher[2] = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;
		tabMode[2] = modeDoubleStart;

		@(posedge rstN);

		startTest();
		readWord(regStatus, word);
		checkValue("status after reset", {96'b0, word}, '0);
		readBlock(regDataOutBase, blk);
		checkValue("data out after reset", blk, '0);
		reportTest("reset state");

		startTest();
		writeWord(regCtrl, 32'h1);
		readWord(regStatus, word);
		checkValue("status after start without key", {96'b0, word}, '0);
		reportTest("start without key");

		for (int e = 0; e < numEntries; e++)
		begin
			startTest();
			loadKey(tabKey[e]);
			if (tabMode[e] == modeDecFirst)
			begin
				runBlock(1'b1, tabCipher[e], 1'b0, blk);
				checkValue($sformatf("vector %0d decryption", e), blk, tabPlain[e]);
				runBlock(1'b0, tabPlain[e], 1'b0, blk);
				checkValue($sformatf("vector %0d encryption", e), blk, tabCipher[e]);
			end
			else
			begin
				runBlock(1'b0, tabPlain[e], tabMode[e] == modeDoubleStart, blk);
				checkValue($sformatf("vector %0d encryption", e), blk, tabCipher[e]);
				runBlock(1'b1, tabCipher[e], 1'b0, blk);
				checkValue($sformatf("vector %0d decryption", e), blk, tabPlain[e]);
			end
			reportTest($sformatf("known answer %0d", e));
		end

		for (int n = 0; n < numRandom; n++)
		begin
			startTest();
			key = randomBlock();
			plain = randomBlock();
			loadKey(key);
			runBlock(1'b0, plain, 1'b0, cipher);
			runBlock(1'b1, cipher, 1'b0, blk);
			checkValue($sformatf("round trip %0d", n), blk, plain);
			reportTest($sformatf("round trip %0d", n));
		end

		$display("%0d tests run, %0d errors", testCount, errorCount);
		if (errorCount == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire
